//--- vaddrgen_top.f
rtl/addrgen_pkg.sv
rtl/insn_checker.sv
rtl/access_sequencer.sv
rtl/addr_queue.sv
rtl/l1_port_driver.sv
rtl/vaddrgen_top.sv
tb/tb_vaddrgen_top.sv

//--- Bender.yml
package:
  name: vaddrgen

sources:
  - rtl/addrgen_pkg.sv
  - rtl/insn_checker.sv
  - rtl/access_sequencer.sv
  - rtl/addr_queue.sv
  - rtl/l1_port_driver.sv
  - rtl/vaddrgen_top.sv
  - target: simulation
    files:
      - tb/tb_vaddrgen_top.sv

//--- tb/tb_vaddrgen_top.sv
// testbench for the vector address generator
`timescale 1ns/1ns
`default_nettype none

module tb_vaddrgen_top import addrgen_pkg::*; ();

  localparam int NumInsns  = 300;
  localparam int WaitLimit = 2000;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  req_valid_i;
  vop_e                  req_op_i;
  addr_t                 req_addr_i;
  vl_t                   req_vl_i;
  addr_t                 req_stride_i;
  vew_t                  req_vew_i;
  logic                  ack_o;
  logic                  error_o;
  logic                  core_st_pending_i;
  logic                  ld_gnt_i;
  logic [IndexWidth-1:0] ld_index_o;
  logic                  ld_data_req_o;
  size_t                 ld_size_o;
  logic [TagWidth-1:0]   ld_tag_o;
  logic                  ld_tag_valid_o;
  logic [IndexWidth-1:0] st_index_o;
  logic [TagWidth-1:0]   st_tag_o;
  size_t                 st_size_o;
  logic                  lsu_req_valid_o;
  addr_t                 lsu_req_addr_o;
  size_t                 lsu_req_size_o;
  logic                  lsu_req_is_load_o;
  logic                  lsu_req_ready_i;

  // expected entries in order as {is_load, size, addr}
  logic [34:0] exp_q[$];
  logic [31:0] lfsr_state;
  l1_addr_u    head_u;
  l1_addr_u    beat_u;
  // load entries already pushed into the dut queue
  int          ld_in_queue;
  int          hold_left;
  logic        hold_active;
  logic        timed_out;
  int          errors;
  int          checks;
  int          entries;
  int          insn_cnt;
  int          reject_cnt;

  vaddrgen_top vaddrgen_top_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_valid_i      (req_valid_i),
    .req_op_i         (req_op_i),
    .req_addr_i       (req_addr_i),
    .req_vl_i         (req_vl_i),
    .req_stride_i     (req_stride_i),
    .req_vew_i        (req_vew_i),
    .ack_o            (ack_o),
    .error_o          (error_o),
    .core_st_pending_i(core_st_pending_i),
    .ld_gnt_i         (ld_gnt_i),
    .ld_index_o       (ld_index_o),
    .ld_data_req_o    (ld_data_req_o),
    .ld_size_o        (ld_size_o),
    .ld_tag_o         (ld_tag_o),
    .ld_tag_valid_o   (ld_tag_valid_o),
    .st_index_o       (st_index_o),
    .st_tag_o         (st_tag_o),
    .st_size_o        (st_size_o),
    .lsu_req_valid_o  (lsu_req_valid_o),
    .lsu_req_addr_o   (lsu_req_addr_o),
    .lsu_req_size_o   (lsu_req_size_o),
    .lsu_req_is_load_o(lsu_req_is_load_o),
    .lsu_req_ready_i  (lsu_req_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // galois lfsr stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ ({32{lfsr_state[0]}} & 32'h8020_0003);
    end
    return val;
  endfunction

  // position of the lowest set bit of a non-zero value
  function automatic int low_zero_bits(input logic [2:0] low);
    int z;
    z = 0;
    while (z < 2 && !low[z]) begin
      z++;
    end
    return z;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // one clock then fresh back-pressure
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
    ld_gnt_i        = (take_bits(2) != 32'd0);
    lsu_req_ready_i = (take_bits(2) != 32'd0);
    if (hold_left > 0) begin
      hold_left--;
    end
    hold_active       = (hold_left > 0);
    core_st_pending_i = hold_active ? 1'b1 : (take_bits(2) == 32'd0);
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  task automatic build_expected(input vop_e op, input addr_t addr, input vl_t vl,
                                input vew_t vew, input addr_t stride,
                                output logic exp_err);
    addr_t base;
    logic  is_load;
    logic  is_unit;
    int    sz;
    int    bytes;
    int    beats;
    base    = addr + MemBase;
    is_load = (op == VLE) || (op == VLSE);
    is_unit = (op == VLE) || (op == VSE);
    exp_err = (addr % (32'd1 << vew)) != 32'd0;
    if (exp_err) begin
      return;
    end
    if (is_unit) begin
      bytes = int'(vl) << vew;
      sz    = 3;
      // store off the bus grid narrows every beat
      if (!is_load && base[2:0] != 3'b000) begin
        sz = low_zero_bits(base[2:0]);
      end
      beats = (bytes + (1 << sz) - 1) >> sz;
      for (int k = 0; k < beats; k++) begin
        exp_q.push_back({is_load, 2'(sz), base + addr_t'(k << sz)});
      end
    end else begin
      for (int k = 0; k < int'(vl); k++) begin
        exp_q.push_back({is_load, vew, base + addr_t'(k) * stride});
      end
    end
  endtask

  // queue head, l1 ports and the pending stall
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (error_o && !ack_o) begin
        errors++;
        $display("error_o is high without ack_o");
      end
      if (hold_active && (lsu_req_valid_o || ld_data_req_o)) begin
        errors++;
        $display("request issued while core_st_pending_i was held high");
      end
      // index phase of the load beat pushed on the coming edge
      if (ld_data_req_o && ld_gnt_i) begin
        if (ld_in_queue >= exp_q.size()) begin
          errors++;
          $display("load beat issued that the model does not expect");
        end else begin
          beat_u.flat = exp_q[ld_in_queue][31:0];
          check_value("ld_data_req_o", ld_data_req_o, exp_q[ld_in_queue][34]);
          check_value("ld_index_o", ld_index_o, beat_u.split.index);
          check_value("ld_size_o", ld_size_o, exp_q[ld_in_queue][33:32]);
        end
        ld_in_queue++;
      end
      if (lsu_req_valid_o && exp_q.size() == 0) begin
        errors++;
        $display("queue shows an entry that the model does not expect");
      end else if (lsu_req_valid_o) begin
        head_u.flat = exp_q[0][31:0];
        if (exp_q[0][34]) begin
          check_value("ld_tag_valid_o", ld_tag_valid_o, 32'd1);
          check_value("ld_tag_o", ld_tag_o, head_u.split.tag);
          check_value("st_index_o", st_index_o, 32'd0);
          check_value("st_tag_o", st_tag_o, 32'd0);
          check_value("st_size_o", st_size_o, 32'd0);
        end else begin
          check_value("ld_tag_valid_o", ld_tag_valid_o, 32'd0);
          check_value("ld_tag_o", ld_tag_o, 32'd0);
          check_value("st_index_o", st_index_o, head_u.split.index);
          check_value("st_tag_o", st_tag_o, head_u.split.tag);
          check_value("st_size_o", st_size_o, exp_q[0][33:32]);
        end
        // popped on the coming edge
        if (lsu_req_ready_i) begin
          check_value("lsu_req_addr_o", lsu_req_addr_o, exp_q[0][31:0]);
          check_value("lsu_req_size_o", lsu_req_size_o, exp_q[0][33:32]);
          check_value("lsu_req_is_load_o", lsu_req_is_load_o, exp_q[0][34]);
          if (exp_q[0][34] && ld_in_queue > 0) begin
            ld_in_queue--;
          end
          void'(exp_q.pop_front());
          entries++;
        end
      end else begin
        check_value("ld_tag_valid_o", ld_tag_valid_o, 32'd0);
        check_value("ld_tag_o", ld_tag_o, 32'd0);
        check_value("st_index_o", st_index_o, 32'd0);
        check_value("st_tag_o", st_tag_o, 32'd0);
        check_value("st_size_o", st_size_o, 32'd0);
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic drain_queue();
    int cycles;
    cycles = 0;
    do begin
      next_cycle();
      cycles++;
    end while ((exp_q.size() != 0 || lsu_req_valid_o) && cycles < WaitLimit);
    if (exp_q.size() != 0 || lsu_req_valid_o) begin
      errors++;
      timed_out = 1'b1;
      $display("queue did not drain within %0d cycles, %0d entries missing",
               WaitLimit, exp_q.size());
    end
  endtask

  task automatic wait_ack(input logic exp_err);
    int cycles;
    cycles = 0;
    do begin
      next_cycle();
      cycles++;
    end while (!ack_o && cycles < WaitLimit);
    if (!ack_o) begin
      errors++;
      timed_out = 1'b1;
      $display("no ack_o within %0d cycles of a request", WaitLimit);
    end else begin
      check_value("error_o", error_o, exp_err);
      req_valid_i = 1'b0;
    end
  endtask

  task automatic run_instruction();
    vop_e  op;
    addr_t addr;
    vl_t   vl;
    vew_t  vew;
    addr_t stride;
    logic  exp_err;
    op     = vop_e'(take_bits(2));
    vl     = vl_t'(take_bits(5) % 20 + 1);
    vew    = vew_t'(take_bits(2));
    addr   = take_bits(20);
    // mostly element-aligned and a quarter fully random
    if (take_bits(2) != 32'd3) begin
      addr = addr & ~((addr_t'(1) << vew) - addr_t'(1));
    end
    stride = take_bits(12);
    build_expected(op, addr, vl, vew, stride, exp_err);
    if (exp_err) begin
      reject_cnt++;
    end
    insn_cnt++;

    req_valid_i  = 1'b1;
    req_op_i     = op;
    req_addr_i   = addr;
    req_vl_i     = vl;
    req_stride_i = stride;
    req_vew_i    = vew;
    // sometimes a store still pending in the core
    hold_left = (take_bits(1) != 32'd0) ? int'(take_bits(3)) + 1 : 0;
    hold_active       = (hold_left > 0);
    core_st_pending_i = hold_active;
    wait_ack(exp_err);
  endtask

  initial begin
    lfsr_state        = 32'h8654_b3fe;
    rst_ni            = 1'b0;
    req_valid_i       = 1'b0;
    req_op_i          = VLE;
    req_addr_i        = '0;
    req_vl_i          = '0;
    req_stride_i      = '0;
    req_vew_i         = '0;
    core_st_pending_i = 1'b0;
    ld_gnt_i          = 1'b0;
    lsu_req_ready_i   = 1'b0;
    ld_in_queue       = 0;
    hold_left         = 0;
    hold_active       = 1'b0;
    timed_out         = 1'b0;
    errors            = 0;
    checks            = 0;
    entries           = 0;
    insn_cnt          = 0;
    reject_cnt        = 0;

    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    // quiet outputs out of reset
    check_value("ack_o", ack_o, 32'd0);
    check_value("error_o", error_o, 32'd0);
    check_value("lsu_req_valid_o", lsu_req_valid_o, 32'd0);
    check_value("ld_data_req_o", ld_data_req_o, 32'd0);
    check_value("ld_tag_valid_o", ld_tag_valid_o, 32'd0);

    for (int n = 0; n < NumInsns && !timed_out; n++) begin
      drain_queue();
      if (!timed_out) begin
        run_instruction();
      end
    end
    if (!timed_out) begin
      drain_queue();
    end

    $display("%0d instructions, %0d rejected, %0d entries, %0d checks, %0d errors",
             insn_cnt, reject_cnt, entries, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/vaddrgen_top.sv
// vector load/store address generator
`timescale 1ns/1ns
`default_nettype none

module vaddrgen_top import addrgen_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // instruction interface
  input  logic                  req_valid_i,
  input  vop_e                  req_op_i,
  input  addr_t                 req_addr_i,
  input  vl_t                   req_vl_i,
  input  addr_t                 req_stride_i,
  input  vew_t                  req_vew_i,
  output logic                  ack_o,
  output logic                  error_o,
  input  logic                  core_st_pending_i,
  // l1 load port
  input  logic                  ld_gnt_i,
  output logic [IndexWidth-1:0] ld_index_o,
  output logic                  ld_data_req_o,
  output size_t                 ld_size_o,
  output logic [TagWidth-1:0]   ld_tag_o,
  output logic                  ld_tag_valid_o,
  // l1 store port
  output logic [IndexWidth-1:0] st_index_o,
  output logic [TagWidth-1:0]   st_tag_o,
  output size_t                 st_size_o,
  // load/store units
  output logic                  lsu_req_valid_o,
  output addr_t                 lsu_req_addr_o,
  output size_t                 lsu_req_size_o,
  output logic                  lsu_req_is_load_o,
  input  logic                  lsu_req_ready_i
);

  // checker to sequencer
  logic  cmd_valid;
  addr_t cmd_addr;
  vl_t   cmd_vl;
  addr_t cmd_stride;
  vew_t  cmd_vew;
  logic  cmd_is_load;
  logic  cmd_is_unit;
  logic  cmd_done;

  // sequencer to queue
  logic  q_push;
  addr_t q_addr;
  size_t q_size;
  logic  q_is_load;
  logic  q_full;

  insn_checker i_checker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_vl_i     (req_vl_i),
    .req_stride_i (req_stride_i),
    .req_vew_i    (req_vew_i),
    .cmd_done_i   (cmd_done),
    .cmd_valid_o  (cmd_valid),
    .cmd_addr_o   (cmd_addr),
    .cmd_vl_o     (cmd_vl),
    .cmd_stride_o (cmd_stride),
    .cmd_vew_o    (cmd_vew),
    .cmd_is_load_o(cmd_is_load),
    .cmd_is_unit_o(cmd_is_unit),
    .ack_o        (ack_o),
    .error_o      (error_o)
  );

  access_sequencer i_sequencer (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cmd_valid_i      (cmd_valid),
    .cmd_addr_i       (cmd_addr),
    .cmd_vl_i         (cmd_vl),
    .cmd_stride_i     (cmd_stride),
    .cmd_vew_i        (cmd_vew),
    .cmd_is_load_i    (cmd_is_load),
    .cmd_is_unit_i    (cmd_is_unit),
    .cmd_done_o       (cmd_done),
    .core_st_pending_i(core_st_pending_i),
    .ld_gnt_i         (ld_gnt_i),
    .ld_index_o       (ld_index_o),
    .ld_data_req_o    (ld_data_req_o),
    .ld_size_o        (ld_size_o),
    .q_full_i         (q_full),
    .q_push_o         (q_push),
    .q_addr_o         (q_addr),
    .q_size_o         (q_size),
    .q_is_load_o      (q_is_load)
  );

  // one ready for both units
  addr_queue i_queue (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .push_i   (q_push),
    .addr_i   (q_addr),
    .size_i   (q_size),
    .is_load_i(q_is_load),
    .full_o   (q_full),
    .ready_i  (lsu_req_ready_i),
    .valid_o  (lsu_req_valid_o),
    .addr_o   (lsu_req_addr_o),
    .size_o   (lsu_req_size_o),
    .is_load_o(lsu_req_is_load_o)
  );

  // queue head drives the tag phase and the store port
  l1_port_driver i_port_driver (
    .head_valid_i  (lsu_req_valid_o),
    .head_addr_i   (lsu_req_addr_o),
    .head_size_i   (lsu_req_size_o),
    .head_is_load_i(lsu_req_is_load_o),
    .ld_tag_o      (ld_tag_o),
    .ld_tag_valid_o(ld_tag_valid_o),
    .st_index_o    (st_index_o),
    .st_tag_o      (st_tag_o),
    .st_size_o     (st_size_o)
  );

endmodule

`default_nettype wire

//--- rtl/l1_port_driver.sv
// l1 port driver
`timescale 1ns/1ns
`default_nettype none

module l1_port_driver import addrgen_pkg::*; (
  // queue head
  input  logic                  head_valid_i,
  input  addr_t                 head_addr_i,
  input  size_t                 head_size_i,
  input  logic                  head_is_load_i,
  // load port, tag phase
  output logic [TagWidth-1:0]   ld_tag_o,
  output logic                  ld_tag_valid_o,
  // store port
  output logic [IndexWidth-1:0] st_index_o,
  output logic [TagWidth-1:0]   st_tag_o,
  output size_t                 st_size_o
);

  l1_addr_u head_u;
  logic     head_ld;
  logic     head_st;

  // tag/index view of the head address
  assign head_u.flat = head_addr_i;

  assign head_ld = head_valid_i && head_is_load_i;
  assign head_st = head_valid_i && !head_is_load_i;

  //////////////////////////////////////////////////
  // port routing
  //////////////////////////////////////////////////

  always_comb begin
    ld_tag_o       = '0;
    ld_tag_valid_o = 1'b0;
    st_index_o     = '0;
    st_tag_o       = '0;
    st_size_o      = '0;

    if (head_ld) begin
      // index went out when the beat was pushed
      ld_tag_o       = head_u.split.tag;
      ld_tag_valid_o = 1'b1;
    end

    if (head_st) begin
      // whole store address in one go
      st_index_o = head_u.split.index;
      st_tag_o   = head_u.split.tag;
      st_size_o  = head_size_i;
    end
  end

endmodule

`default_nettype wire

//--- rtl/addr_queue.sv
// request queue toward the load/store units
`timescale 1ns/1ns
`default_nettype none

module addr_queue import addrgen_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  // write side
  input  logic   push_i,
  input  addr_t  addr_i,
  input  size_t  size_i,
  input  logic   is_load_i,
  output logic   full_o,
  // read side
  input  logic   ready_i,
  output logic   valid_o,
  output addr_t  addr_o,
  output size_t  size_o,
  output logic   is_load_o
);

  // storage
  addr_t addr_mem    [QueueDepth];
  size_t size_mem    [QueueDepth];
  logic  is_load_mem [QueueDepth];

  logic [QPtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [QPtrWidth:0]   count_q;
  logic                 pop;

  assign full_o  = (count_q == (QPtrWidth + 1)'(QueueDepth));
  assign valid_o = (count_q != '0);
  assign pop     = valid_o && ready_i;

  // head entry
  assign addr_o    = addr_mem[rd_ptr_q];
  assign size_o    = size_mem[rd_ptr_q];
  assign is_load_o = is_load_mem[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // pointers wrap on the power-of-two depth
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + QPtrWidth'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + QPtrWidth'(1);
      end
      count_q <= count_q + (QPtrWidth + 1)'(push_i) - (QPtrWidth + 1)'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      addr_mem[wr_ptr_q]    <= addr_i;
      size_mem[wr_ptr_q]    <= size_i;
      is_load_mem[wr_ptr_q] <= is_load_i;
    end
  end

  a_fill_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= (QPtrWidth + 1)'(QueueDepth));

endmodule

`default_nettype wire

//--- rtl/access_sequencer.sv
// access sequencer
// turns a command into single-beat requests
`timescale 1ns/1ns
`default_nettype none

module access_sequencer import addrgen_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // command from the checker
  input  logic                  cmd_valid_i,
  input  addr_t                 cmd_addr_i,
  input  vl_t                   cmd_vl_i,
  input  addr_t                 cmd_stride_i,
  input  vew_t                  cmd_vew_i,
  input  logic                  cmd_is_load_i,
  input  logic                  cmd_is_unit_i,
  output logic                  cmd_done_o,
  // core still has stores in flight
  input  logic                  core_st_pending_i,
  // l1 load port, index phase
  input  logic                  ld_gnt_i,
  output logic [IndexWidth-1:0] ld_index_o,
  output logic                  ld_data_req_o,
  output size_t                 ld_size_o,
  // request queue
  input  logic                  q_full_i,
  output logic                  q_push_o,
  output addr_t                 q_addr_o,
  output size_t                 q_size_o,
  output logic                  q_is_load_o
);

  // widest power of two the low address bits allow
  function automatic size_t trailing_zeros(logic [BusBytesLog-1:0] low);
    size_t cnt;
    cnt = '0;
    for (int i = BusBytesLog - 1; i >= 0; i--) begin
      if (low[i]) begin
        cnt = size_t'(i);
      end
    end
    return cnt;
  endfunction

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_MISALIGNED,
    SEQ_WAITING,
    SEQ_REQUESTING
  } seq_state_e;

  seq_state_e state_q, state_d;

  // current beat
  addr_t addr_q, addr_d;
  size_t size_q, size_d;
  // bytes left for unit-stride, elements left for strided
  logic [RemWidth-1:0] remain_q, remain_d;
  logic [RemWidth-1:0] step_bytes;

  addr_t stride_q;
  logic  is_load_q;
  logic  is_unit_q;

  logic  beat_ok;

  //////////////////////////////////////////////////
  // beat generation
  //////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    addr_d        = addr_q;
    size_d        = size_q;
    remain_d      = remain_q;
    cmd_done_o    = 1'b0;
    ld_data_req_o = 1'b0;
    ld_index_o    = '0;
    ld_size_o     = '0;
    beat_ok       = 1'b0;
    step_bytes    = RemWidth'(1) << size_q;

    case (state_q)
      SEQ_IDLE: begin
        if (cmd_valid_i) begin
          addr_d = cmd_addr_i;
          if (cmd_is_unit_i) begin
            // full bus beats, count in bytes
            remain_d = RemWidth'(cmd_vl_i) << cmd_vew_i;
            size_d   = size_t'(BusBytesLog);
          end else begin
            // one element per beat
            remain_d = RemWidth'(cmd_vl_i);
            size_d   = cmd_vew_i;
          end
          // unit-stride store off the bus grid needs a narrower beat
          if (cmd_is_unit_i && !cmd_is_load_i && (cmd_addr_i[BusBytesLog-1:0] != '0)) begin
            state_d = SEQ_MISALIGNED;
          end else if (core_st_pending_i) begin
            state_d = SEQ_WAITING;
          end else begin
            state_d = SEQ_REQUESTING;
          end
        end
      end
      SEQ_MISALIGNED: begin
        size_d  = trailing_zeros(addr_q[BusBytesLog-1:0]);
        state_d = core_st_pending_i ? SEQ_WAITING : SEQ_REQUESTING;
      end
      SEQ_WAITING: begin
        if (!core_st_pending_i) begin
          state_d = SEQ_REQUESTING;
        end
      end
      SEQ_REQUESTING: begin
        if (is_load_q) begin
          // index phase, only while the queue has room
          ld_data_req_o = !q_full_i;
          ld_index_o    = addr_q[IndexWidth-1:0];
          ld_size_o     = size_q;
          beat_ok       = !q_full_i && ld_gnt_i;
        end else begin
          beat_ok = !q_full_i;
        end

        if (beat_ok) begin
          if (is_unit_q) begin
            // saturate, the last beat may overshoot
            remain_d = (remain_q > step_bytes) ? remain_q - step_bytes : '0;
            addr_d   = addr_q + addr_t'(step_bytes);
          end else begin
            remain_d = remain_q - RemWidth'(1);
            addr_d   = addr_q + stride_q;
          end
          if (remain_d == '0) begin
            cmd_done_o = 1'b1;
            state_d    = SEQ_IDLE;
          end
        end
      end
      default: state_d = SEQ_IDLE;
    endcase
  end

  assign q_push_o    = beat_ok;
  assign q_addr_o    = addr_q;
  assign q_size_o    = size_q;
  assign q_is_load_o = is_load_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SEQ_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // beat payload
  always_ff @(posedge clk_i) begin
    addr_q   <= addr_d;
    size_q   <= size_d;
    remain_q <= remain_d;
    if (state_q == SEQ_IDLE && cmd_valid_i) begin
      stride_q  <= cmd_stride_i;
      is_load_q <= cmd_is_load_i;
      is_unit_q <= cmd_is_unit_i;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // checker passes vl straight from the requester
  a_vl_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == SEQ_IDLE && cmd_valid_i) |-> (cmd_vl_i != '0));

  // full flag comes back from the queue
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    q_full_i |-> !q_push_o);

endmodule

`default_nettype wire

//--- rtl/insn_checker.sv
// instruction checker
`timescale 1ns/1ns
`default_nettype none

module insn_checker import addrgen_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  // instruction from the requester
  input  logic   req_valid_i,
  input  vop_e   req_op_i,
  input  addr_t  req_addr_i,
  input  vl_t    req_vl_i,
  input  addr_t  req_stride_i,
  input  vew_t   req_vew_i,
  // command toward the sequencer
  input  logic   cmd_done_i,
  output logic   cmd_valid_o,
  output addr_t  cmd_addr_o,
  output vl_t    cmd_vl_o,
  output addr_t  cmd_stride_o,
  output vew_t   cmd_vew_o,
  output logic   cmd_is_load_o,
  output logic   cmd_is_unit_o,
  // completion
  output logic   ack_o,
  output logic   error_o
);

  // any address bit below the element width set
  function automatic logic addr_misaligned(addr_t addr, vew_t vew);
    addr_t mask;
    mask = (addr_t'(1) << vew) - addr_t'(1);
    return |(addr & mask);
  endfunction

  typedef enum logic [1:0] {
    CHK_IDLE,
    CHK_CHECK,
    CHK_BUSY
  } chk_state_e;

  chk_state_e state_q, state_d;

  // latched instruction
  vop_e  op_q;
  addr_t addr_q;
  vl_t   vl_q;
  addr_t stride_q;
  vew_t  vew_q;

  logic misal_q;
  logic ack_d, error_d;

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    ack_d   = 1'b0;
    error_d = 1'b0;
    case (state_q)
      CHK_IDLE: begin
        if (req_valid_i) begin
          state_d = CHK_CHECK;
        end
      end
      // misaligned flag gets registered here
      CHK_CHECK: state_d = CHK_BUSY;
      CHK_BUSY: begin
        if (misal_q) begin
          // rejected, never shown to the sequencer
          ack_d   = 1'b1;
          error_d = 1'b1;
          state_d = CHK_IDLE;
        end else if (cmd_done_i) begin
          ack_d   = 1'b1;
          state_d = CHK_IDLE;
        end
      end
      default: state_d = CHK_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CHK_IDLE;
      misal_q <= 1'b0;
      ack_o   <= 1'b0;
      error_o <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_o   <= ack_d;
      error_o <= error_d;
      if (state_q == CHK_CHECK) begin
        misal_q <= addr_misaligned(addr_q, vew_q);
      end
    end
  end

  // instruction held for the whole command
  always_ff @(posedge clk_i) begin
    if (state_q == CHK_IDLE && req_valid_i) begin
      op_q     <= req_op_i;
      addr_q   <= req_addr_i;
      vl_q     <= req_vl_i;
      stride_q <= req_stride_i;
      vew_q    <= req_vew_i;
    end
  end

  //////////////////////////////////////////////////
  // command
  //////////////////////////////////////////////////

  assign cmd_valid_o   = (state_q == CHK_BUSY) && !misal_q;
  // scalar base into the memory window
  assign cmd_addr_o    = addr_q + MemBase;
  assign cmd_vl_o      = vl_q;
  assign cmd_stride_o  = stride_q;
  assign cmd_vew_o     = vew_q;
  assign cmd_is_load_o = (op_q == VLE) || (op_q == VLSE);
  assign cmd_is_unit_o = (op_q == VLE) || (op_q == VSE);

  a_err_with_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    error_o |-> ack_o);

endmodule

`default_nettype wire

//--- rtl/addrgen_pkg.sv
// vector address generator
// shared widths and types
`default_nettype none

package addrgen_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // memory address
  localparam int unsigned AddrWidth   = 32;
  // element count of one instruction
  localparam int unsigned VlWidth     = 10;
  // l1 index incl. byte offset
  localparam int unsigned IndexWidth  = 12;
  localparam int unsigned TagWidth    = AddrWidth - IndexWidth;

  // data bus toward the l1
  localparam int unsigned BusBytes    = 8;
  localparam int unsigned BusBytesLog = $clog2(BusBytes);

  // byte counter, vl scaled up to double elements
  localparam int unsigned RemWidth    = VlWidth + 3;

  // request queue toward the load/store units
  localparam int unsigned QueueDepth  = 2;
  localparam int unsigned QPtrWidth   = $clog2(QueueDepth);

  // offset of the vector memory window
  localparam logic [AddrWidth-1:0] MemBase = 32'h8011_6000;

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [VlWidth-1:0]   vl_t;
  // log2 of beat bytes
  typedef logic [1:0]           size_t;
  // log2 of element bytes: byte, half, word, double
  typedef logic [1:0]           vew_t;

  typedef enum logic [1:0] {
    // unit-stride load and store
    VLE,
    VSE,
    // strided load and store
    VLSE,
    VSSE
  } vop_e;

  // same word seen flat or as tag/index for the l1
  typedef union packed {
    addr_t flat;
    struct packed {
      logic [TagWidth-1:0]   tag;
      logic [IndexWidth-1:0] index;
    } split;
  } l1_addr_u;

endpackage

`default_nettype wire
